//--- design/mm_ram_pkg.sv
// address map, test codes, bus word types and controller enums for the RAM subsystem
`default_nettype none

package mm_ram_pkg;

    // a data or address word on the bus
    typedef logic [31:0] word_t;

    // one enable bit per byte lane of a word
    typedef logic [3:0] be_t;

    // byte address width of the RAM, 4 KiB in total
    localparam int unsigned RAM_ADDR_WIDTH = 12;

    // width of a word index into the RAM
    localparam int unsigned RAM_IDX_WIDTH = RAM_ADDR_WIDTH - 2;

    // depth of the RAM in words
    localparam int unsigned RAM_WORDS = 2 ** RAM_IDX_WIDTH;

    // the timer count register
    localparam word_t TIMER_ADDR = 32'h1500_0000;

    // status register of the test control block
    localparam word_t STATUS_ADDR = 32'h2000_0000;

    // exit register, one word above the status register
    localparam word_t EXIT_ADDR = 32'h2000_0004;

    // status values written by the program under test
    localparam word_t TEST_PASS_CODE = 32'd123456789;
    localparam word_t TEST_FAIL_CODE = 32'd1;

    // read data returned when nothing answers at an address
    localparam word_t UNMAPPED_RDATA = 32'hdead_beef;

    // slave selected by the address decoder
    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_TIMER,
        TGT_TEST,
        TGT_NONE
    } target_e;

    // states of the request controller
    typedef enum logic [1:0] {
        // no response due this cycle
        ST_IDLE,
        // response for last cycle's grant goes out
        ST_RESP,
        // exit seen, nothing more is granted
        ST_HALT
    } ctrl_state_e;

endpackage : mm_ram_pkg

`default_nettype wire

//--- design/periph_bus_if.sv
// periph_bus_if, a slave bus with same-edge request and registered read data
`timescale 1ns/10ps
`default_nettype none

interface periph_bus_if;

    // request strobe, one cycle per transfer
    logic req;

    // write when high, read when low
    logic we;

    // byte lanes taking part in a write
    mm_ram_pkg::be_t be;

    // word offset inside the slave's range
    mm_ram_pkg::word_t addr;

    mm_ram_pkg::word_t wdata;

    // read data, valid the cycle after a read request
    mm_ram_pkg::word_t rdata;

    // the controller side drives the request fields
    modport master (
        output req,
        output we,
        output be,
        output addr,
        output wdata,
        input  rdata
    );

    // the slave acts on req at the clock edge and answers with rdata
    modport slave (
        input  req,
        input  we,
        input  be,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface : periph_bus_if

`default_nettype wire

//--- design/mm_ram_ctrl.sv
// request grant FSM with address decode, response mux and halt after exit
`timescale 1ns/10ps
`default_nettype none

module mm_ram_ctrl (
    input  wire logic               clk_i,
    input  wire logic               reset_i,

    input  wire logic               data_req_i,
    input  mm_ram_pkg::word_t       data_addr_i,
    input  wire logic               data_we_i,
    input  mm_ram_pkg::be_t         data_be_i,
    input  mm_ram_pkg::word_t       data_wdata_i,
    output logic                    data_gnt_o,
    output mm_ram_pkg::word_t       data_rdata_o,
    output logic                    data_rvalid_o,

    input  wire logic               exit_valid_i,

    periph_bus_if.master            ram_bus,
    periph_bus_if.master            timer_bus,
    periph_bus_if.master            test_bus
);

    mm_ram_pkg::ctrl_state_e state_q;
    mm_ram_pkg::ctrl_state_e state_d;
    mm_ram_pkg::target_e     tgt;
    mm_ram_pkg::target_e     tgt_q;
    logic                    gnt;

    // the RAM sits at the bottom of the address map
    always_comb begin
        if (data_addr_i[31:mm_ram_pkg::RAM_ADDR_WIDTH] == '0) begin
            tgt = mm_ram_pkg::TGT_RAM;
        end else if (data_addr_i == mm_ram_pkg::TIMER_ADDR) begin
            tgt = mm_ram_pkg::TGT_TIMER;
        end else if (data_addr_i == mm_ram_pkg::STATUS_ADDR ||
                     data_addr_i == mm_ram_pkg::EXIT_ADDR) begin
            tgt = mm_ram_pkg::TGT_TEST;
        end else begin
            tgt = mm_ram_pkg::TGT_NONE;
        end
    end

    // grant at once unless halted
    // exit_valid_i already closes the gate in the response cycle of the exit write
    assign gnt = data_req_i && (state_q != mm_ram_pkg::ST_HALT) && !exit_valid_i;
    assign data_gnt_o = gnt;

    // only the decoded slave sees the request
    assign ram_bus.req   = gnt && (tgt == mm_ram_pkg::TGT_RAM);
    assign timer_bus.req = gnt && (tgt == mm_ram_pkg::TGT_TIMER);
    assign test_bus.req  = gnt && (tgt == mm_ram_pkg::TGT_TEST);

    assign ram_bus.we   = data_we_i;
    assign timer_bus.we = data_we_i;
    assign test_bus.we  = data_we_i;

    assign ram_bus.be   = data_be_i;
    assign timer_bus.be = data_be_i;
    assign test_bus.be  = data_be_i;

    assign ram_bus.wdata   = data_wdata_i;
    assign timer_bus.wdata = data_wdata_i;
    assign test_bus.wdata  = data_wdata_i;

    // the RAM gets its word index, the timer has a single register and bit 2 picks status or exit
    assign ram_bus.addr   = mm_ram_pkg::word_t'(data_addr_i[mm_ram_pkg::RAM_ADDR_WIDTH-1:2]);
    assign timer_bus.addr = '0;
    assign test_bus.addr  = mm_ram_pkg::word_t'(data_addr_i[2]);

    always_comb begin
        if (exit_valid_i) begin
            state_d = mm_ram_pkg::ST_HALT;
        end else if (gnt) begin
            state_d = mm_ram_pkg::ST_RESP;
        end else begin
            state_d = mm_ram_pkg::ST_IDLE;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= mm_ram_pkg::ST_IDLE;
            tgt_q   <= mm_ram_pkg::TGT_NONE;
        end else begin
            state_q <= state_d;
            if (gnt) begin
                tgt_q <= tgt;
            end
        end
    end

    // ST_RESP lasts exactly the cycle after a grant
    assign data_rvalid_o = (state_q == mm_ram_pkg::ST_RESP);

    always_comb begin
        case (tgt_q)
            mm_ram_pkg::TGT_RAM:   data_rdata_o = ram_bus.rdata;
            mm_ram_pkg::TGT_TIMER: data_rdata_o = timer_bus.rdata;
            mm_ram_pkg::TGT_TEST:  data_rdata_o = test_bus.rdata;
            default:               data_rdata_o = mm_ram_pkg::UNMAPPED_RDATA;
        endcase
    end

    // every transfer is answered on the following cycle
    a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
        (data_req_i && data_gnt_o) |=> data_rvalid_o);

    // once halted the port stays closed until reset
    a_halt_until_reset: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == mm_ram_pkg::ST_HALT) |=> (state_q == mm_ram_pkg::ST_HALT) && !data_gnt_o);

endmodule : mm_ram_ctrl

`default_nettype wire

//--- design/mm_ram_store.sv
// mm_ram_store, word RAM with byte-enable writes and registered read data
`timescale 1ns/10ps
`default_nettype none

module mm_ram_store (
    input  wire logic     clk_i,
    periph_bus_if.slave   bus
);

    mm_ram_pkg::word_t mem [mm_ram_pkg::RAM_WORDS];
    logic [mm_ram_pkg::RAM_IDX_WIDTH-1:0] idx;

    // the controller already hands over a word index
    assign idx = bus.addr[mm_ram_pkg::RAM_IDX_WIDTH-1:0];

    // only the enabled lanes of a word change on a write
    always_ff @(posedge clk_i) begin
        if (bus.req && bus.we) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.be[b]) begin
                    mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
                end
            end
        end
    end

    // read data is held until the next read
    always_ff @(posedge clk_i) begin
        if (bus.req && !bus.we) begin
            bus.rdata <= mem[idx];
        end
    end

    // the decoder must never hand over an index past the end of the array
    a_addr_in_range: assert property (@(posedge clk_i)
        bus.req |-> (bus.addr < mm_ram_pkg::RAM_WORDS));

endmodule : mm_ram_store

`default_nettype wire

//--- design/mm_timer.sv
// mm_timer, count-down timer with readable count and an acknowledged timer interrupt
`timescale 1ns/10ps
`default_nettype none

module mm_timer (
    input  wire logic     clk_i,
    input  wire logic     reset_i,
    periph_bus_if.slave   bus,
    input  wire logic     irq_ack_i,
    output logic          irq_timer_o
);

    mm_ram_pkg::word_t count_q;
    logic              irq_q;
    logic              expire;

    // the step from 1 down to 0 is the timeout event
    assign expire = (count_q == 32'd1) && !(bus.req && bus.we);

    // a write reloads the count, a zero stops it without an interrupt
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= '0;
        end else if (bus.req && bus.we) begin
            count_q <= bus.wdata;
        end else if (count_q != '0) begin
            count_q <= count_q - 32'd1;
        end
    end

    // a fresh timeout wins over an acknowledge in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            irq_q <= 1'b0;
        end else if (expire) begin
            irq_q <= 1'b1;
        end else if (irq_ack_i) begin
            irq_q <= 1'b0;
        end
    end

    assign irq_timer_o = irq_q;

    // reads see the count as it stands in the request cycle
    always_ff @(posedge clk_i) begin
        if (bus.req && !bus.we) begin
            bus.rdata <= count_q;
        end
    end

    // partial writes to the count register make no sense to software
    a_full_word_write: assert property (@(posedge clk_i) disable iff (reset_i)
        (bus.req && bus.we) |-> (bus.be == 4'hf));

endmodule : mm_timer

`default_nettype wire

//--- design/mm_test_ctrl.sv
// mm_test_ctrl, sticky pass and fail flags plus the exit value register
`timescale 1ns/10ps
`default_nettype none

module mm_test_ctrl (
    input  wire logic         clk_i,
    input  wire logic         reset_i,
    periph_bus_if.slave       bus,
    output logic              tests_passed_o,
    output logic              tests_failed_o,
    output mm_ram_pkg::word_t exit_value_o,
    output logic              exit_valid_o
);

    logic status_wr;
    logic exit_wr;

    // offset 0 is the status register, offset 1 the exit register
    assign status_wr = bus.req && bus.we && (bus.addr[0] == 1'b0);
    assign exit_wr   = bus.req && bus.we && (bus.addr[0] == 1'b1);

    // flags only ever set, status values other than the two codes are ignored
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
        end else if (status_wr) begin
            if (bus.wdata == mm_ram_pkg::TEST_PASS_CODE) begin
                tests_passed_o <= 1'b1;
            end else if (bus.wdata == mm_ram_pkg::TEST_FAIL_CODE) begin
                tests_failed_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            exit_valid_o <= 1'b0;
            exit_value_o <= '0;
        end else if (exit_wr) begin
            exit_valid_o <= 1'b1;
            exit_value_o <= bus.wdata;
        end
    end

    // both offsets read back the exit value
    always_ff @(posedge clk_i) begin
        if (bus.req && !bus.we) begin
            bus.rdata <= exit_value_o;
        end
    end

endmodule : mm_test_ctrl

`default_nettype wire

//--- design/mm_ram.sv
// mm_ram, top level joining the request controller, RAM, timer and test control
`timescale 1ns/10ps
`default_nettype none

module mm_ram (
    input  wire logic         clk_i,
    input  wire logic         reset_i,

    // data port of the core
    input  wire logic         data_req_i,
    input  mm_ram_pkg::word_t data_addr_i,
    input  wire logic         data_we_i,
    input  mm_ram_pkg::be_t   data_be_i,
    input  mm_ram_pkg::word_t data_wdata_i,
    output logic              data_gnt_o,
    output mm_ram_pkg::word_t data_rdata_o,
    output logic              data_rvalid_o,

    // timer interrupt and its acknowledge
    input  wire logic         irq_ack_i,
    output logic              irq_timer_o,

    // test status seen by the simulation environment
    output logic              tests_passed_o,
    output logic              tests_failed_o,
    output mm_ram_pkg::word_t exit_value_o,
    output logic              exit_valid_o
);

    // one bus per slave behind the controller
    periph_bus_if ram_bus ();
    periph_bus_if timer_bus ();
    periph_bus_if test_bus ();

    mm_ram_ctrl ctrl_i (
        .clk_i         ( clk_i         ),
        .reset_i       ( reset_i       ),
        .data_req_i    ( data_req_i    ),
        .data_addr_i   ( data_addr_i   ),
        .data_we_i     ( data_we_i     ),
        .data_be_i     ( data_be_i     ),
        .data_wdata_i  ( data_wdata_i  ),
        .data_gnt_o    ( data_gnt_o    ),
        .data_rdata_o  ( data_rdata_o  ),
        .data_rvalid_o ( data_rvalid_o ),
        .exit_valid_i  ( exit_valid_o  ),
        .ram_bus       ( ram_bus       ),
        .timer_bus     ( timer_bus     ),
        .test_bus      ( test_bus      )
    );

    mm_ram_store store_i (
        .clk_i ( clk_i   ),
        .bus   ( ram_bus )
    );

    mm_timer timer_i (
        .clk_i       ( clk_i       ),
        .reset_i     ( reset_i     ),
        .bus         ( timer_bus   ),
        .irq_ack_i   ( irq_ack_i   ),
        .irq_timer_o ( irq_timer_o )
    );

    // its exit flag also halts the controller
    mm_test_ctrl test_ctrl_i (
        .clk_i          ( clk_i          ),
        .reset_i        ( reset_i        ),
        .bus            ( test_bus       ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_value_o   ( exit_value_o   ),
        .exit_valid_o   ( exit_valid_o   )
    );

endmodule : mm_ram

`default_nettype wire

//--- sim/tb_mm_ram_checks.svh
// compare tasks for bus words, flags and irq level, the error exit and the timeout waits
`ifndef TB_MM_RAM_CHECKS_SVH
`define TB_MM_RAM_CHECKS_SVH

task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "run stopped at the first error");
endtask

task automatic check_word(input string name, input mm_ram_pkg::word_t exp_v,
                          input mm_ram_pkg::word_t act_v);
    if (act_v !== exp_v) begin
        abort_run($sformatf("FAIL %s expected %h actual %h", name, exp_v, act_v));
    end
endtask

// single status or handshake bit
task automatic check_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
        abort_run($sformatf("FAIL %s expected %b actual %b", name, exp_v, act_v));
    end
endtask

task automatic check_irq(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
        abort_run($sformatf("FAIL %s irq expected %b actual %b", name, exp_v, act_v));
    end
endtask

// returns at the falling edge of the grant cycle, or after limit cycles without one
task automatic wait_grant(input int limit, output bit granted);
    int n;
    granted = 1'b0;
    n = 0;
    while (!granted && n < limit) begin
        @(negedge clk);
        granted = (data_gnt === 1'b1);
        n++;
    end
endtask

task automatic wait_irq(input int limit, output logic seen);
    int n;
    seen = 1'b0;
    n = 0;
    while (!seen && n < limit) begin
        @(negedge clk);
        seen = (irq_timer === 1'b1);
        n++;
    end
endtask

`endif

//--- sim/tb_mm_ram.sv
// testbench top with clock, reset, operation table, bus driver tasks and the main test sequence
`timescale 1ns/10ps
`default_nettype none

module tb_mm_ram;

    localparam int GNT_LIMIT  = 20;
    localparam int IRQ_LIMIT  = 100;
    localparam int HALT_LIMIT = 50;
    localparam int RAND_WORDS = 16;
    localparam int MAX_ROWS   = 32;
    localparam mm_ram_pkg::word_t TIMER_LOAD = 32'd20;
    localparam mm_ram_pkg::word_t EXIT_CODE  = 32'h0000_002a;

    typedef enum {OP_WRITE, OP_READ, OP_IRQ, OP_STATUS} op_e;

    logic              clk;
    logic              reset;
    logic              data_req;
    logic              data_we;
    mm_ram_pkg::word_t data_addr;
    mm_ram_pkg::be_t   data_be;
    mm_ram_pkg::word_t data_wdata;
    logic              data_gnt;
    logic              data_rvalid;
    mm_ram_pkg::word_t data_rdata;
    logic              irq_ack;
    logic              irq_timer;
    logic              tests_passed;
    logic              tests_failed;
    logic              exit_valid;
    mm_ram_pkg::word_t exit_value;

    int                seed = 32'h2a76;
    int unsigned       cycle = 0;
    int unsigned       last_gnt_cycle;
    mm_ram_pkg::word_t ref_mem [RAND_WORDS];

    // the operation table keeps one entry per row in each array
    int                n_rows = 0;
    string             row_name [MAX_ROWS];
    op_e               row_kind [MAX_ROWS];
    mm_ram_pkg::word_t row_addr [MAX_ROWS];
    mm_ram_pkg::word_t row_wdata [MAX_ROWS];
    mm_ram_pkg::be_t   row_be [MAX_ROWS];
    mm_ram_pkg::word_t row_expect [MAX_ROWS];

    mm_ram dut_i (
        .clk_i          ( clk          ),
        .reset_i        ( reset        ),
        .data_req_i     ( data_req     ),
        .data_addr_i    ( data_addr    ),
        .data_we_i      ( data_we      ),
        .data_be_i      ( data_be      ),
        .data_wdata_i   ( data_wdata   ),
        .data_gnt_o     ( data_gnt     ),
        .data_rdata_o   ( data_rdata   ),
        .data_rvalid_o  ( data_rvalid  ),
        .irq_ack_i      ( irq_ack      ),
        .irq_timer_o    ( irq_timer    ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_value_o   ( exit_value   ),
        .exit_valid_o   ( exit_valid   )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic add_row(input string name, input op_e kind, input mm_ram_pkg::word_t addr,
                           input mm_ram_pkg::word_t wdata, input mm_ram_pkg::be_t be,
                           input mm_ram_pkg::word_t expect_word);
        row_name[n_rows]   = name;
        row_kind[n_rows]   = kind;
        row_addr[n_rows]   = addr;
        row_wdata[n_rows]  = wdata;
        row_be[n_rows]     = be;
        row_expect[n_rows] = expect_word;
        n_rows++;
    endtask

    // performs one complete transfer whose response must come in the cycle after the grant
    task automatic bus_access(input string name, input logic we, input mm_ram_pkg::word_t addr,
                              input mm_ram_pkg::word_t wdata, input mm_ram_pkg::be_t be,
                              output mm_ram_pkg::word_t rdata);
        bit granted;
        @(posedge clk);
        #10;
        data_req   = 1'b1;
        data_we    = we;
        data_addr  = addr;
        data_wdata = wdata;
        data_be    = be;
        wait_grant(GNT_LIMIT, granted);
        if (!granted) begin
            abort_run({name, ": the request was never granted"});
        end
        last_gnt_cycle = cycle;
        check_flag({name, " rvalid before response"}, 1'b0, data_rvalid);
        @(posedge clk);
        #10;
        data_req = 1'b0;
        @(negedge clk);
        check_flag({name, " rvalid"}, 1'b1, data_rvalid);
        rdata = data_rdata;
    endtask

    // reads the reference words with the request held high so grants come in consecutive cycles
    task automatic read_burst(input string name);
        bit granted;
        for (int i = 0; i <= RAND_WORDS; i++) begin
            @(posedge clk);
            #10;
            data_req  = (i < RAND_WORDS);
            data_we   = 1'b0;
            data_addr = mm_ram_pkg::word_t'(i * 4);
            if (i < RAND_WORDS) begin
                wait_grant(GNT_LIMIT, granted);
                if (!granted) begin
                    abort_run({name, ": a burst read was never granted"});
                end
            end else begin
                @(negedge clk);
            end
            if (i > 0) begin
                check_flag($sformatf("%s[%0d] rvalid", name, i - 1), 1'b1, data_rvalid);
                check_word($sformatf("%s[%0d]", name, i - 1), ref_mem[i - 1], data_rdata);
            end
        end
    endtask

    // expect_cycles of zero means no interrupt may show up at all
    task automatic irq_row(input string name, input mm_ram_pkg::word_t expect_cycles,
                           input int unsigned load_cycle);
        logic seen;
        wait_irq(IRQ_LIMIT, seen);
        if (expect_cycles == '0) begin
            check_irq(name, 1'b0, seen);
        end else begin
            if (!seen) begin
                abort_run({name, ": the timer interrupt never rose"});
            end
            check_word(name, expect_cycles, mm_ram_pkg::word_t'(cycle - load_cycle));
            @(posedge clk);
            #10;
            irq_ack = 1'b1;
            @(negedge clk);
            check_irq({name, " held until ack"}, 1'b1, irq_timer);
            @(posedge clk);
            #10;
            irq_ack = 1'b0;
            @(negedge clk);
            check_irq({name, " after ack"}, 1'b0, irq_timer);
        end
    endtask

    initial begin
        mm_ram_pkg::word_t rdata;
        mm_ram_pkg::word_t wdata;
        mm_ram_pkg::be_t   be;
        bit                granted;
        int                idx;
        int unsigned       load_cycle;
        reset      = 1'b1;
        data_req   = 1'b0;
        data_we    = 1'b0;
        data_addr  = '0;
        data_be    = '0;
        data_wdata = '0;
        irq_ack    = 1'b0;
        load_cycle = 0;

        add_row("ram_seed", OP_WRITE, 32'h0000_0040, 32'h1122_3344, 4'hf, '0);
        add_row("ram_seed_lane2", OP_WRITE, 32'h0000_0040, 32'h00aa_0000, 4'b0100, '0);
        add_row("ram_seed_read", OP_READ, 32'h0000_0040, '0, 4'hf, 32'h11aa_3344);
        // a wrong decoder would alias this address just above the RAM onto word 16
        // and the fail code would show in the flags if the write leaked into the test block
        add_row("unmapped_write", OP_WRITE, 32'h0000_1040, mm_ram_pkg::TEST_FAIL_CODE,
                4'hf, '0);
        add_row("ram_after_unmapped", OP_READ, 32'h0000_0040, '0, 4'hf, 32'h11aa_3344);
        add_row("unmapped_read", OP_READ, 32'h3000_0000, '0, 4'hf, mm_ram_pkg::UNMAPPED_RDATA);
        add_row("status_after_unmapped", OP_STATUS, '0, '0, 4'h0, 32'h0);
        add_row("timer_load", OP_WRITE, mm_ram_pkg::TIMER_ADDR, TIMER_LOAD, 4'hf, '0);
        // this read is granted two cycles after the load when one decrement has happened
        add_row("timer_count", OP_READ, mm_ram_pkg::TIMER_ADDR, '0, 4'hf, TIMER_LOAD - 32'd1);
        add_row("timer_irq", OP_IRQ, '0, '0, 4'h0, TIMER_LOAD + 32'd1);
        add_row("timer_reload", OP_WRITE, mm_ram_pkg::TIMER_ADDR, 32'd30, 4'hf, '0);
        add_row("timer_stop", OP_WRITE, mm_ram_pkg::TIMER_ADDR, 32'd0, 4'hf, '0);
        add_row("timer_silent", OP_IRQ, '0, '0, 4'h0, 32'd0);
        add_row("status_fail", OP_WRITE, mm_ram_pkg::STATUS_ADDR, mm_ram_pkg::TEST_FAIL_CODE,
                4'hf, '0);
        add_row("status_fail_flags", OP_STATUS, '0, '0, 4'h0, 32'h2);
        add_row("status_other", OP_WRITE, mm_ram_pkg::STATUS_ADDR, 32'h0000_0007, 4'hf, '0);
        add_row("status_other_flags", OP_STATUS, '0, '0, 4'h0, 32'h2);
        add_row("status_pass", OP_WRITE, mm_ram_pkg::STATUS_ADDR, mm_ram_pkg::TEST_PASS_CODE,
                4'hf, '0);
        add_row("status_pass_flags", OP_STATUS, '0, '0, 4'h0, 32'h3);
        add_row("exit_write", OP_WRITE, mm_ram_pkg::EXIT_ADDR, EXIT_CODE, 4'hf, '0);
        add_row("exit_flags", OP_STATUS, '0, '0, 4'h0, 32'h7);

        repeat (8) @(posedge clk);
        #10;
        reset = 1'b0;

        // full words first so every byte of the reference is known
        for (int i = 0; i < RAND_WORDS; i++) begin
            ref_mem[i] = $random(seed);
            bus_access("ram_init", 1'b1, mm_ram_pkg::word_t'(i * 4), ref_mem[i], 4'hf, rdata);
        end
        for (int i = 0; i < 3 * RAND_WORDS; i++) begin
            idx   = {$random(seed)} % RAND_WORDS;
            wdata = $random(seed);
            be    = mm_ram_pkg::be_t'($random(seed));
            bus_access("ram_merge", 1'b1, mm_ram_pkg::word_t'(idx * 4), wdata, be, rdata);
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ref_mem[idx][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        for (int i = 0; i < RAND_WORDS; i++) begin
            bus_access("ram_read", 1'b0, mm_ram_pkg::word_t'(i * 4), '0, 4'hf, rdata);
            check_word($sformatf("ram_read[%0d]", i), ref_mem[i], rdata);
        end
        read_burst("ram_burst");

        for (int r = 0; r < n_rows; r++) begin
            case (row_kind[r])
                OP_WRITE: begin
                    bus_access(row_name[r], 1'b1, row_addr[r], row_wdata[r], row_be[r], rdata);
                    if (row_addr[r] == mm_ram_pkg::TIMER_ADDR) begin
                        load_cycle = last_gnt_cycle;
                    end
                end
                OP_READ: begin
                    bus_access(row_name[r], 1'b0, row_addr[r], '0, row_be[r], rdata);
                    check_word(row_name[r], row_expect[r], rdata);
                end
                OP_IRQ: begin
                    irq_row(row_name[r], row_expect[r], load_cycle);
                end
                default: begin
                    // expected word holds exit_valid, failed and passed from bit 2 down
                    @(negedge clk);
                    check_flag({row_name[r], " passed"}, row_expect[r][0], tests_passed);
                    check_flag({row_name[r], " failed"}, row_expect[r][1], tests_failed);
                    check_flag({row_name[r], " exit_valid"}, row_expect[r][2], exit_valid);
                end
            endcase
        end
        check_word("exit_value", EXIT_CODE, exit_value);

        // the port is closed after exit so this wait has to run out
        @(posedge clk);
        #10;
        data_req  = 1'b1;
        data_we   = 1'b0;
        data_addr = '0;
        wait_grant(HALT_LIMIT, granted);
        check_flag("grant_after_exit", 1'b0, granted);

        $display("Verification passed");
        $finish;
    end

    `include "tb_mm_ram_checks.svh"

endmodule : tb_mm_ram

`default_nettype wire

//--- riscv_mm_ram.f
+incdir+sim
design/mm_ram_pkg.sv
design/periph_bus_if.sv
design/mm_ram_ctrl.sv
design/mm_ram_store.sv
design/mm_timer.sv
design/mm_test_ctrl.sv
design/mm_ram.sv
sim/tb_mm_ram.sv

//--- Bender.yml
package:
  name: riscv_mm_ram

sources:
  # package and interface come first, the RTL top level last
  - design/mm_ram_pkg.sv
  - design/periph_bus_if.sv
  - design/mm_ram_ctrl.sv
  - design/mm_ram_store.sv
  - design/mm_timer.sv
  - design/mm_test_ctrl.sv
  - design/mm_ram.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mm_ram.sv
